//--- rv_core.f
+incdir+rtl
rtl/rv_core_pkg.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_result.sv
rtl/rv_core.sv
testbench/rv_core_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module rv_core_tb -f rv_core.f -o rv_core_sim

out=$(./obj_dir/rv_core_sim)
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1

//--- testbench/rv_core_tb.sv
`timescale 1ns/1ns
`include "rv_core_consts.svh"

module rv_core_tb;

    import rv_core_pkg::*;

    // Roughly 150 instructions at worst-case stalls plus margin
    localparam int WATCHDOG_NS     = 400_000;
    // Keeps the 3-bit output credit counter far from wrapping
    localparam int MAX_OUTSTANDING = 4;
    // Decode, execute and result registers that fill behind a blocked output
    localparam int STAGE_REGS      = 3;

    logic                i_clk;
    logic                i_rstn;
    logic                i_insn_vld;
    logic [`RV_XLEN-1:0] i_insn;
    logic                i_res_credit;
    logic                o_in_credit;
    logic                o_res_vld;
    res_t                o_res;

    logic [`RV_XLEN-1:0] ref_regs [32];
    logic [`RV_XLEN-1:0] insn_q [$];
    res_t                exp_q [$];
    int                  in_credits;
    int                  credit_pulses;
    int                  sent_count;
    int                  results_seen;
    int                  grants_given;
    int                  grant_left;
    logic                auto_grant;
    int                  mismatches;
    int                  failures;
    int unsigned         seed;

    rv_core rv_core_inst (
        .i_clk        (i_clk),
        .i_rstn       (i_rstn),
        .i_insn_vld   (i_insn_vld),
        .i_insn       (i_insn),
        .o_in_credit  (o_in_credit),
        .i_res_credit (i_res_credit),
        .o_res_vld    (o_res_vld),
        .o_res        (o_res)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    initial begin
        #WATCHDOG_NS;
        $display("Watchdog expired at %0t, the run did not finish in time", $time);
        $display("Test failed");
        $finish;
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `RV_OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, `RV_OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] lui_insn(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, `RV_OPC_LUI};
    endfunction

    // RV32I integer semantics by funct3 where alt picks SUB and SRA
    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // Expected record for one instruction and its model register update
    function automatic res_t predict(input logic [31:0] insn);
        res_t        r;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] value;
        logic        bad;
        f7    = insn[31:25];
        f3    = insn[14:12];
        rd    = insn[11:7];
        a     = ref_regs[insn[19:15]];
        value = '0;
        bad   = 1'b0;
        case (insn[6:0])
            `RV_OPC_OP: begin
                bad = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
                value = ref_alu(f3, f7 == 7'h20, a, ref_regs[insn[24:20]]);
            end
            `RV_OPC_OP_IMM: begin
                if (f3 == 3'b001) begin
                    bad = (f7 != 7'h00);
                end else if (f3 == 3'b101) begin
                    bad = !(f7 == 7'h00 || f7 == 7'h20);
                end
                value = ref_alu(f3, f3 == 3'b101 && f7 == 7'h20, a,
                                {{20{insn[31]}}, insn[31:20]});
            end
            `RV_OPC_LUI: value = {insn[31:12], 12'h000};
            default:     bad = 1'b1;
        endcase
        if (bad) begin
            value = '0;
        end else if (rd != 5'd0) begin
            ref_regs[rd] = value;
        end
        r.rd      = rd;
        r.value   = value;
        r.illegal = bad;
        return r;
    endfunction

    // One clock of sampling outputs and then driving the next inputs
    task automatic cycle();
        res_t expected;
        @(negedge i_clk);
        if (o_in_credit) begin
            in_credits++;
            credit_pulses++;
        end
        if (o_res_vld) begin
            results_seen++;
            if (exp_q.size() == 0) begin
                $display("Result at %0t with no instruction outstanding", $time);
                failures++;
            end else begin
                expected = exp_q.pop_front();
                if (o_res !== expected) begin
                    $display("MISMATCH %0t: rd %0d value %h illegal %b, expected %0d %h %b",
                             $time, o_res.rd, o_res.value, o_res.illegal,
                             expected.rd, expected.value, expected.illegal);
                    mismatches++;
                end
            end
        end
        i_insn_vld   = 1'b0;
        i_res_credit = 1'b0;
        if (grant_left > 0 && (grants_given - results_seen) < MAX_OUTSTANDING) begin
            i_res_credit = 1'b1;
            grant_left--;
            grants_given++;
        end
        if (insn_q.size() > 0 && in_credits > 0) begin
            i_insn_vld = 1'b1;
            i_insn     = insn_q.pop_front();
            in_credits--;
            sent_count++;
        end
    endtask

    task automatic send(input logic [31:0] insn);
        insn_q.push_back(insn);
        exp_q.push_back(predict(insn));
        if (auto_grant) begin
            grant_left++;
        end
    endtask

    // LUI plus ADDI with the upper part rounded for the sign-extended low half
    task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
        send(lui_insn(value[31:12] + {19'b0, value[11]}, rd));
        send(i_type(value[11:0], rd, 3'b000, rd));
    endtask

    task automatic wait_results(input int max_cycles);
        int n;
        n = 0;
        while ((exp_q.size() != 0 || insn_q.size() != 0) && n < max_cycles) begin
            cycle();
            n++;
        end
        if (exp_q.size() != 0 || insn_q.size() != 0) begin
            $display("Timed out at %0t with %0d results missing", $time, exp_q.size());
            failures++;
            exp_q.delete();
            insn_q.delete();
        end
        repeat (2) cycle();
        if (in_credits != `RV_IN_DEPTH) begin
            $display("MISMATCH %0t: producer holds %0d input credits, expected %0d",
                     $time, in_credits, `RV_IN_DEPTH);
            mismatches++;
        end
    endtask

    task automatic idle_after_reset();
        repeat (10) begin
            cycle();
            if (o_res_vld || o_in_credit) begin
                $display("Output active at %0t while idle after reset", $time);
                failures++;
            end
        end
    endtask

    task automatic lui_and_opimm();
        logic [11:0] imm;
        for (int i = 0; i < 8; i++) begin
            send(lui_insn(20'($urandom()), 5'(1 + i)));
            imm = 12'($urandom());
            // Shift immediates need a legal funct7 field
            if (i == 1) begin
                imm[11:5] = 7'h00;
            end else if (i == 5) begin
                imm[11:5] = ($urandom_range(1) == 1) ? 7'h20 : 7'h00;
            end
            send(i_type(imm, 5'(1 + i), 3'(i), 5'(9 + i)));
        end
        wait_results(300);
    endtask

    task automatic all_reg_ops();
        logic [2:0] f3;
        logic [6:0] f7;
        load_reg(5'd1, 32'h8000_0000);
        load_reg(5'd2, 32'hffff_ffff);
        for (int r = 3; r <= 6; r++) begin
            load_reg(5'(r), $urandom());
        end
        for (int rep = 0; rep < 3; rep++) begin
            for (int op = 0; op < 10; op++) begin
                f3 = (op < 8) ? 3'(op) : ((op == 8) ? 3'b000 : 3'b101);
                f7 = (op >= 8) ? 7'h20 : 7'h00;
                send(r_type(f7, 5'(1 + $urandom_range(5)), 5'(1 + $urandom_range(5)), f3,
                            5'(7 + op)));
            end
        end
        wait_results(400);
    endtask

    // Sources one, two and three back cover both forwards and the bypass
    task automatic dependent_chains();
        logic [4:0] hist [16];
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3;
        logic [6:0] f7;
        load_reg(5'd10, $urandom());
        for (int i = 0; i < 16; i++) begin
            hist[i] = 5'(11 + i % 6);
            f3 = 3'($urandom_range(7));
            f7 = ((f3 == 3'b000 || f3 == 3'b101) && $urandom_range(1) == 1) ? 7'h20 : 7'h00;
            rs1 = (i == 0) ? 5'd10 : hist[i-1];
            if (i < 3) begin
                rs2 = 5'd10;
            end else begin
                rs2 = (i % 2 == 1) ? hist[i-2] : hist[i-3];
            end
            send(r_type(f7, rs2, rs1, f3, hist[i]));
        end
        for (int i = 0; i < 8; i++) begin
            send(i_type(12'($urandom()), 5'd20, 3'b000, 5'd20));
        end
        wait_results(400);
    endtask

    task automatic output_backpressure();
        int base_res;
        int base_pulses;
        int base_sent;
        base_res    = results_seen;
        base_pulses = credit_pulses;
        base_sent   = sent_count;
        auto_grant  = 1'b0;
        for (int i = 0; i < 12; i++) begin
            send(i_type(12'($urandom()), 5'(1 + $urandom_range(14)), 3'b000, 5'(21 + i % 8)));
        end
        grant_left = 2;
        repeat (40) cycle();
        if (results_seen - base_res != 2) begin
            $display("MISMATCH %0t: %0d results with 2 credits", $time, results_seen - base_res);
            mismatches++;
        end
        if (credit_pulses - base_pulses > sent_count - base_sent) begin
            $display("More input credits returned than instructions sent");
            failures++;
        end
        // Two results left and every stage register behind them is full
        if (credit_pulses - base_pulses != 2 + STAGE_REGS) begin
            $display("MISMATCH %0t: %0d input credits returned, expected %0d",
                     $time, credit_pulses - base_pulses, 2 + STAGE_REGS);
            mismatches++;
        end
        if (insn_q.size() == 0) begin
            $display("Back-pressure never reached the input port");
            failures++;
        end
        grant_left = 10;
        auto_grant = 1'b1;
        wait_results(300);
    endtask

    task automatic illegal_and_x0();
        logic [31:0] bad [6];
        bad[0] = {25'($urandom()), 7'b0000011};
        bad[1] = {25'($urandom()), 7'b0100011};
        bad[2] = {25'($urandom()), 7'b1100011};
        bad[3] = {25'($urandom()), 7'b1101111};
        // MUL and a SLLI with a nonzero funct7
        bad[4] = r_type(7'h01, 5'd3, 5'd4, 3'b000, 5'd5);
        bad[5] = {7'h20, 5'd3, 5'd4, 3'b001, 5'd6, `RV_OPC_OP_IMM};
        for (int i = 0; i < 6; i++) begin
            send(bad[i]);
            send(i_type(12'h000, bad[i][11:7], 3'b000, 5'd23));
        end
        send(i_type(12'($urandom()), 5'd22, 3'b000, 5'd0));
        send(lui_insn(20'($urandom()), 5'd0));
        send(r_type(7'h00, 5'd22, 5'd22, 3'b000, 5'd0));
        send(i_type(12'h000, 5'd0, 3'b000, 5'd24));
        send(r_type(7'h00, 5'd0, 5'd0, 3'b110, 5'd25));
        wait_results(300);
    endtask

    initial begin
        seed = 69;
        void'($urandom(seed));
        i_rstn        = 1'b0;
        i_insn_vld    = 1'b0;
        i_insn        = '0;
        i_res_credit  = 1'b0;
        in_credits    = `RV_IN_DEPTH;
        credit_pulses = 0;
        sent_count    = 0;
        results_seen  = 0;
        grants_given  = 0;
        grant_left    = 0;
        auto_grant    = 1'b1;
        mismatches    = 0;
        failures      = 0;
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
        end
        repeat (5) @(posedge i_clk);
        @(negedge i_clk);
        i_rstn = 1'b1;

        idle_after_reset();
        lui_and_opimm();
        all_reg_ops();
        dependent_chains();
        output_backpressure();
        illegal_and_x0();

        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- rtl/rv_core.sv
`timescale 1ns/1ns
`include "rv_core_consts.svh"

module rv_core (
    input  logic                 i_clk,
    input  logic                 i_rstn,
    input  logic                 i_insn_vld,
    input  logic [`RV_XLEN-1:0]  i_insn,
    output logic                 o_in_credit,
    input  logic                 i_res_credit,
    output logic                 o_res_vld,
    output rv_core_pkg::res_t    o_res
);

    import rv_core_pkg::*;

    logic [`RV_REG_ADDR_W-1:0] rs1_addr;
    logic [`RV_REG_ADDR_W-1:0] rs2_addr;
    logic [`RV_XLEN-1:0]       rs1_data;
    logic [`RV_XLEN-1:0]       rs2_data;
    logic                      wr_en;
    logic [`RV_REG_ADDR_W-1:0] wr_addr;
    logic [`RV_XLEN-1:0]       wr_data;
    logic                      stall_req;
    logic                      stall;
    dec_t                      dec_item;
    ex_t                       ex_item;
    ex_t                       res_item;

    // Output back-pressure is the only stall source
    assign stall = stall_req;

    rv_regfile rv_regfile_inst (
        .i_clk      (i_clk),
        .i_rstn     (i_rstn),
        .i_rs1_addr (rs1_addr),
        .i_rs2_addr (rs2_addr),
        .i_wr_en    (wr_en),
        .i_wr_addr  (wr_addr),
        .i_wr_data  (wr_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    rv_decode rv_decode_inst (
        .i_clk       (i_clk),
        .i_rstn      (i_rstn),
        .i_insn_vld  (i_insn_vld),
        .i_insn      (i_insn),
        .i_stall     (stall),
        .i_rs1_data  (rs1_data),
        .i_rs2_data  (rs2_data),
        .o_rs1_addr  (rs1_addr),
        .o_rs2_addr  (rs2_addr),
        .o_in_credit (o_in_credit),
        .o_dec       (dec_item)
    );

    rv_execute rv_execute_inst (
        .i_clk     (i_clk),
        .i_rstn    (i_rstn),
        .i_stall   (stall),
        .i_dec     (dec_item),
        .i_res_fwd (res_item),
        .o_ex      (ex_item)
    );

    rv_result rv_result_inst (
        .i_clk        (i_clk),
        .i_rstn       (i_rstn),
        .i_stall      (stall),
        .i_ex         (ex_item),
        .i_res_credit (i_res_credit),
        .o_res_vld    (o_res_vld),
        .o_res        (o_res),
        .o_cur        (res_item),
        .o_wr_en      (wr_en),
        .o_wr_addr    (wr_addr),
        .o_wr_data    (wr_data),
        .o_stall_req  (stall_req)
    );

endmodule

//--- rtl/rv_result.sv
`timescale 1ns/1ns
`include "rv_core_consts.svh"

module rv_result (
    input  logic                      i_clk,
    input  logic                      i_rstn,
    input  logic                      i_stall,
    input  rv_core_pkg::ex_t          i_ex,
    input  logic                      i_res_credit,
    output logic                      o_res_vld,
    output rv_core_pkg::res_t         o_res,
    output rv_core_pkg::ex_t          o_cur,
    output logic                      o_wr_en,
    output logic [`RV_REG_ADDR_W-1:0] o_wr_addr,
    output logic [`RV_XLEN-1:0]       o_wr_data,
    output logic                      o_stall_req
);

    import rv_core_pkg::*;

    logic [`RV_OUT_CREDITS_W-1:0] credits;
    logic                         has_credit;
    logic                         emit;

    assign has_credit = (credits != '0);
    assign emit       = o_cur.valid && has_credit;

    // Held item with nothing to spend stalls the whole pipe
    assign o_stall_req = o_cur.valid && !has_credit;

    // Emitting implies no stall, so the next item replaces the one that left
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_cur <= '0;
        end else if (!i_stall) begin
            o_cur <= i_ex;
        end
    end

    // One credit per consumer pulse, one spent per result
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            credits <= '0;
        end else begin
            credits <= credits + i_res_credit - emit;
        end
    end

    assign o_res_vld     = emit;
    assign o_res.rd      = o_cur.rd;
    assign o_res.value   = o_cur.value;
    assign o_res.illegal = o_cur.illegal;

    // Write-back happens in the same cycle the result leaves
    assign o_wr_en   = emit && o_cur.rd_wr;
    assign o_wr_addr = o_cur.rd;
    assign o_wr_data = o_cur.value;

endmodule

//--- rtl/rv_execute.sv
`timescale 1ns/1ns
`include "rv_core_consts.svh"

module rv_execute (
    input  logic                i_clk,
    input  logic                i_rstn,
    input  logic                i_stall,
    input  rv_core_pkg::dec_t   i_dec,
    input  rv_core_pkg::ex_t    i_res_fwd,
    output rv_core_pkg::ex_t    o_ex
);

    import rv_core_pkg::*;

    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_result;

    // True when an older item will write the source register
    function automatic logic fwd_hit(input ex_t item, input logic [`RV_REG_ADDR_W-1:0] src);
        return item.valid && item.rd_wr && (item.rd != '0) && (item.rd == src);
    endfunction

    // Youngest producer wins, then the result stage, then the register file read
    function automatic logic [`RV_XLEN-1:0] fwd_src(
        input logic [`RV_REG_ADDR_W-1:0] src,
        input logic [`RV_XLEN-1:0]       rf_data,
        input ex_t                       ex_item,
        input ex_t                       res_item
    );
        logic [`RV_XLEN-1:0] val;
        if (fwd_hit(ex_item, src)) begin
            val = ex_item.value;
        end else if (fwd_hit(res_item, src)) begin
            val = res_item.value;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    assign rs1_val = fwd_src(i_dec.rs1, i_dec.rs1_data, o_ex, i_res_fwd);
    assign rs2_val = fwd_src(i_dec.rs2, i_dec.rs2_data, o_ex, i_res_fwd);
    assign op_b    = i_dec.imm_sel ? i_dec.imm : rs2_val;

    rv_alu rv_alu_inst (
        .i_op_a   (rs1_val),
        .i_op_b   (op_b),
        .i_alu_op (i_dec.alu_op),
        .o_result (alu_result)
    );

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_ex <= '0;
        end else if (!i_stall) begin
            o_ex.valid   <= i_dec.valid;
            o_ex.rd      <= i_dec.rd;
            o_ex.rd_wr   <= i_dec.rd_wr;
            o_ex.illegal <= i_dec.illegal;
            // Illegal items report a zero value
            o_ex.value   <= i_dec.illegal ? '0 : alu_result;
        end
    end

endmodule

//--- rtl/rv_decode.sv
`timescale 1ns/1ns
`include "rv_core_consts.svh"

module rv_decode (
    input  logic                      i_clk,
    input  logic                      i_rstn,
    input  logic                      i_insn_vld,
    input  logic [`RV_XLEN-1:0]       i_insn,
    input  logic                      i_stall,
    input  logic [`RV_XLEN-1:0]       i_rs1_data,
    input  logic [`RV_XLEN-1:0]       i_rs2_data,
    output logic [`RV_REG_ADDR_W-1:0] o_rs1_addr,
    output logic [`RV_REG_ADDR_W-1:0] o_rs2_addr,
    output logic                      o_in_credit,
    output rv_core_pkg::dec_t         o_dec
);

    import rv_core_pkg::*;

    localparam int PTR_W = $clog2(`RV_IN_DEPTH);

    logic [`RV_XLEN-1:0] fifo_mem [`RV_IN_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [PTR_W:0]      count;
    logic                pop;
    logic [`RV_XLEN-1:0] head;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic                f7_zero;
    logic                f7_alt;
    dec_t                dec_d;

    // Base operation from funct3, alt selects SUB or SRA
    function automatic alu_op_e funct3_op(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? SUB : ADD;
            3'b001:  op = SLL;
            3'b010:  op = SLT;
            3'b011:  op = SLTU;
            3'b100:  op = XOR;
            3'b101:  op = alt ? SRA : SRL;
            3'b110:  op = OR;
            default: op = AND;
        endcase
        return op;
    endfunction

    // The producer never writes into a full FIFO, its credits forbid it
    assign pop = !i_stall && (count != '0);

    always_ff @(posedge i_clk) begin
        if (i_insn_vld) begin
            fifo_mem[wr_ptr] <= i_insn;
        end
    end

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            o_in_credit <= 1'b0;
        end else begin
            if (i_insn_vld) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count       <= count + i_insn_vld - pop;
            o_in_credit <= pop;
        end
    end

    assign head       = fifo_mem[rd_ptr];
    assign funct3     = head[14:12];
    assign funct7     = head[31:25];
    assign f7_zero    = (funct7 == 7'h00);
    assign f7_alt     = (funct7 == 7'h20);
    assign o_rs1_addr = head[19:15];
    assign o_rs2_addr = head[24:20];

    always_comb begin
        dec_d          = '0;
        dec_d.valid    = pop;
        dec_d.rd       = head[11:7];
        dec_d.rs1      = head[19:15];
        dec_d.rs2      = head[24:20];
        dec_d.rs1_data = i_rs1_data;
        dec_d.rs2_data = i_rs2_data;
        dec_d.alu_op   = ADD;
        dec_d.imm      = {{20{head[31]}}, head[31:20]};
        dec_d.rd_wr    = 1'b1;
        case (opcode_e'(head[6:0]))
            OPC_OP: begin
                dec_d.alu_op  = funct3_op(funct3, f7_alt);
                dec_d.illegal = !(f7_zero ||
                                  (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            OPC_OP_IMM: begin
                dec_d.imm_sel = 1'b1;
                dec_d.alu_op  = funct3_op(funct3, f7_alt && (funct3 == 3'b101));
                // Shift immediates carry funct7 in the upper bits
                if (funct3 == 3'b001) begin
                    dec_d.illegal = !f7_zero;
                end else if (funct3 == 3'b101) begin
                    dec_d.illegal = !(f7_zero || f7_alt);
                end
            end
            OPC_LUI: begin
                dec_d.imm_sel = 1'b1;
                dec_d.alu_op  = PASS_B;
                dec_d.imm     = {head[31:12], 12'b0};
            end
            default: begin
                dec_d.illegal = 1'b1;
            end
        endcase
        if (dec_d.illegal) begin
            dec_d.rd_wr = 1'b0;
        end
    end

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_dec <= '0;
        end else if (!i_stall) begin
            o_dec <= dec_d;
        end
    end

endmodule

//--- rtl/rv_alu.sv
`timescale 1ns/1ns
`include "rv_core_consts.svh"

module rv_alu (
    input  logic [`RV_XLEN-1:0]    i_op_a,
    input  logic [`RV_XLEN-1:0]    i_op_b,
    input  rv_core_pkg::alu_op_e   i_alu_op,
    output logic [`RV_XLEN-1:0]    o_result
);

    import rv_core_pkg::*;

    logic [4:0] shamt;

    // Only the low five bits shift
    assign shamt = i_op_b[4:0];

    always_comb begin
        case (i_alu_op)
            ADD: begin
                o_result = i_op_a + i_op_b;
            end
            SUB: begin
                o_result = i_op_a - i_op_b;
            end
            SLL: begin
                o_result = i_op_a << shamt;
            end
            SLT: begin
                o_result = {31'b0, $signed(i_op_a) < $signed(i_op_b)};
            end
            SLTU: begin
                o_result = {31'b0, i_op_a < i_op_b};
            end
            XOR: begin
                o_result = i_op_a ^ i_op_b;
            end
            SRL: begin
                o_result = i_op_a >> shamt;
            end
            SRA: begin
                o_result = $unsigned($signed(i_op_a) >>> shamt);
            end
            OR: begin
                o_result = i_op_a | i_op_b;
            end
            AND: begin
                o_result = i_op_a & i_op_b;
            end
            PASS_B: begin
                o_result = i_op_b;
            end
            default: begin
                o_result = '0;
            end
        endcase
    end

endmodule

//--- rtl/rv_regfile.sv
`timescale 1ns/1ns
`include "rv_core_consts.svh"

module rv_regfile (
    input  logic                      i_clk,
    input  logic                      i_rstn,
    input  logic [`RV_REG_ADDR_W-1:0] i_rs1_addr,
    input  logic [`RV_REG_ADDR_W-1:0] i_rs2_addr,
    input  logic                      i_wr_en,
    input  logic [`RV_REG_ADDR_W-1:0] i_wr_addr,
    input  logic [`RV_XLEN-1:0]       i_wr_data,
    output logic [`RV_XLEN-1:0]       o_rs1_data,
    output logic [`RV_XLEN-1:0]       o_rs2_data
);

    localparam int NUM_REGS = 2 ** `RV_REG_ADDR_W;

    logic [`RV_XLEN-1:0] regs [NUM_REGS];

    // x0 is never written
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_addr != '0)) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // Same-cycle write is bypassed onto the read ports
    always_comb begin
        if (i_rs1_addr == '0) begin
            o_rs1_data = '0;
        end else if (i_wr_en && (i_wr_addr == i_rs1_addr)) begin
            o_rs1_data = i_wr_data;
        end else begin
            o_rs1_data = regs[i_rs1_addr];
        end
        if (i_rs2_addr == '0) begin
            o_rs2_data = '0;
        end else if (i_wr_en && (i_wr_addr == i_rs2_addr)) begin
            o_rs2_data = i_wr_data;
        end else begin
            o_rs2_data = regs[i_rs2_addr];
        end
    end

endmodule

//--- rtl/rv_core_pkg.sv
`include "rv_core_consts.svh"

package rv_core_pkg;

    // Supported major opcodes, anything else decodes as illegal
    typedef enum logic [6:0] {
        OPC_OP      = `RV_OPC_OP,
        OPC_OP_IMM  = `RV_OPC_OP_IMM,
        OPC_LUI     = `RV_OPC_LUI,
        OPC_ILLEGAL = 7'b0000000
    } opcode_e;

    // ALU operations, PASS_B forwards operand B for LUI
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10
    } alu_op_e;

    // Decode stage item
    typedef struct packed {
        logic                       valid;
        logic [`RV_REG_ADDR_W-1:0]  rd;
        logic [`RV_REG_ADDR_W-1:0]  rs1;
        logic [`RV_REG_ADDR_W-1:0]  rs2;
        alu_op_e                    alu_op;
        // Operand B from the immediate instead of rs2
        logic                       imm_sel;
        logic [`RV_XLEN-1:0]        imm;
        logic [`RV_XLEN-1:0]        rs1_data;
        logic [`RV_XLEN-1:0]        rs2_data;
        logic                       rd_wr;
        logic                       illegal;
    } dec_t;

    // Execute stage item
    typedef struct packed {
        logic                       valid;
        logic [`RV_REG_ADDR_W-1:0]  rd;
        logic                       rd_wr;
        logic                       illegal;
        logic [`RV_XLEN-1:0]        value;
    } ex_t;

    // Result record on the output port
    typedef struct packed {
        logic [`RV_REG_ADDR_W-1:0]  rd;
        logic [`RV_XLEN-1:0]        value;
        logic                       illegal;
    } res_t;

endpackage

//--- rtl/rv_core_consts.svh
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

// Datapath and instruction width
`define RV_XLEN 32

// Register index width, 32 architectural registers
`define RV_REG_ADDR_W 5

// Input FIFO entries, equal to the producer credits after reset
`define RV_IN_DEPTH 4

// Output credit counter width
`define RV_OUT_CREDITS_W 3

// Major opcode encodings of the supported classes
`define RV_OPC_OP     7'b0110011
`define RV_OPC_OP_IMM 7'b0010011
`define RV_OPC_LUI    7'b0110111

`endif
